/* hdl/io_settings.svh */
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// Processor bus and GPIO pin width
`define IO_DATA_W 8

// Byte address into the register map
`define IO_ADDR_W 8

// Prescaler count and scale factor width
`define IO_PRESCALE_W 16

`endif

/* hdl/io_pkg.sv */
`default_nettype none

`include "io_settings.svh"

package io_pkg;

    // ******************************
    // Register map
    typedef enum logic [`IO_ADDR_W-1:0] {
        DIR      = `IO_ADDR_W'd0,  // Pin direction, 1 drives the pin
        PORT     = `IO_ADDR_W'd1,  // Output latch
        PINS     = `IO_ADDR_W'd2,  // Pin readback, read only
        SCALE_LO = `IO_ADDR_W'd3,
        SCALE_HI = `IO_ADDR_W'd4,
        CTRL     = `IO_ADDR_W'd5,  // Mode in 1:0, routing in 3:2
        CMPR0    = `IO_ADDR_W'd6,
        CMPR1    = `IO_ADDR_W'd7,
        COUNT    = `IO_ADDR_W'd8   // Timer count, read only
    } io_reg_addr_e;

    // ******************************
    // Timer modes from CTRL[1:0]
    typedef enum logic [1:0] {
        IDLE = 2'd0,  // Counter cleared
        CTC  = 2'd1,  // Clear on compare 0
        PWM  = 2'd2,  // Free running, two PWM outputs
        HOLD = 2'd3   // Everything frozen
    } timer_mode_e;

endpackage

`default_nettype wire

/* hdl/timer_cfg_if.sv */
`default_nettype none

`include "io_settings.svh"

interface timer_cfg_if;
    import io_pkg::*;

    // Configuration, register block to timer
    logic [`IO_PRESCALE_W-1:0] scale_factor;
    timer_mode_e               mode;
    logic [`IO_DATA_W-1:0]     cmpr0;
    logic [`IO_DATA_W-1:0]     cmpr1;

    // Status, timer back to register block
    logic [`IO_DATA_W-1:0]     count;
    logic                      out0;
    logic                      out1;

    modport cfg (
        output scale_factor, mode, cmpr0, cmpr1,
        input  count, out0, out1
    );

    modport tmr (
        input  scale_factor, mode, cmpr0, cmpr1,
        output count, out0, out1
    );

endinterface

`default_nettype wire

/* hdl/io_regs.sv */
`default_nettype none

`include "io_settings.svh"

module io_regs (
    input  logic                  clk,
    input  logic                  reset,
    // Processor bus
    input  logic [`IO_ADDR_W-1:0] address,
    input  logic [`IO_DATA_W-1:0] din,
    input  logic                  w_en,
    input  logic                  r_en,
    output logic [`IO_DATA_W-1:0] dout,
    // Pad side
    input  logic [`IO_DATA_W-1:0] pin_in,
    output logic [`IO_DATA_W-1:0] pin_out,
    output logic [`IO_DATA_W-1:0] pin_oe,
    // Timer configuration and status
    timer_cfg_if.cfg              tcfg
);
    import io_pkg::*;

    localparam int ROUTE0_BIT = 2;  // CTRL bit, out0 onto pin 6
    localparam int ROUTE1_BIT = 3;  // CTRL bit, out1 onto pin 7

    io_reg_addr_e          reg_sel;

    logic [`IO_DATA_W-1:0] dir;
    logic [`IO_DATA_W-1:0] port;
    logic [`IO_DATA_W-1:0] scale_lo;
    logic [`IO_DATA_W-1:0] scale_hi;
    logic [`IO_DATA_W-1:0] ctrl;
    logic [`IO_DATA_W-1:0] cmpr0;
    logic [`IO_DATA_W-1:0] cmpr1;

    assign reg_sel = io_reg_addr_e'(address);

    // ******************************
    // Register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            dir      <= '0;
            port     <= '0;
            scale_lo <= '0;
            scale_hi <= '0;
            ctrl     <= '0;
            cmpr0    <= '0;
            cmpr1    <= '0;
        end else if (w_en) begin
            case (reg_sel)
                DIR:      dir      <= din;
                PORT:     port     <= din;
                SCALE_LO: scale_lo <= din;
                SCALE_HI: scale_hi <= din;
                CTRL:     ctrl     <= din;
                CMPR0:    cmpr0    <= din;
                CMPR1:    cmpr1    <= din;
                default:  ;  // PINS, COUNT and unmapped
            endcase
        end
    end

    // ******************************
    // Registered read data
    // Old register value wins on a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else if (r_en) begin
            case (reg_sel)
                DIR:      dout <= dir;
                PORT:     dout <= port;
                PINS:     dout <= pin_in;      // Sampled on the read edge
                SCALE_LO: dout <= scale_lo;
                SCALE_HI: dout <= scale_hi;
                CTRL:     dout <= ctrl;
                CMPR0:    dout <= cmpr0;
                CMPR1:    dout <= cmpr1;
                COUNT:    dout <= tcfg.count;
                default:  ;                    // Unmapped, hold
            endcase
        end
    end

    // ******************************
    // Timer configuration
    assign tcfg.scale_factor = {scale_hi, scale_lo};
    assign tcfg.mode         = timer_mode_e'(ctrl[1:0]);
    assign tcfg.cmpr0        = cmpr0;
    assign tcfg.cmpr1        = cmpr1;

    // Pad drive, timer outputs can take over pins 6 and 7
    assign pin_oe  = dir;
    assign pin_out = {
        ctrl[ROUTE1_BIT] ? tcfg.out1 : port[7],
        ctrl[ROUTE0_BIT] ? tcfg.out0 : port[6],
        port[5:0]
    };

    // Strobes must be driven once out of reset
    a_strobes_known: assert property (
        @(posedge clk) disable iff (reset)
        !($isunknown(w_en) && $isunknown(r_en))
    ) else $error("w_en and r_en both unknown");

endmodule

`default_nettype wire

/* hdl/counter_timer.sv */
`default_nettype none

`include "io_settings.svh"

module counter_timer (
    input  logic     clk,
    input  logic     reset,
    timer_cfg_if.tmr tcfg
);
    import io_pkg::*;

    localparam logic [`IO_DATA_W-1:0] COUNT_TOP = '1;  // Last count of a PWM period

    logic [`IO_PRESCALE_W-1:0] prescaler;
    logic                      tick;
    logic [`IO_DATA_W-1:0]     count;
    logic                      out0;
    logic                      out1;
    logic                      match0;
    logic                      match1;

    // Only for the CTC bound check
    logic                      ctc_synced;
    logic [`IO_DATA_W-1:0]     cmpr0_seen;

    // ******************************
    // Prescaler, one tick per scale_factor+1 clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            prescaler <= '0;
            tick      <= 1'b0;
        end else if (prescaler == tcfg.scale_factor) begin
            prescaler <= '0;
            tick      <= 1'b1;
        end else begin
            prescaler <= prescaler + 1'b1;
            tick      <= 1'b0;
        end
    end

    // Comparators
    assign match0 = (count == tcfg.cmpr0);
    assign match1 = (count == tcfg.cmpr1);

    // ******************************
    // Counter and outputs, advance on tick only
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            out0  <= 1'b0;
            out1  <= 1'b0;
        end else if (tick) begin
            case (tcfg.mode)
                IDLE: begin
                    count <= '0;
                    out0  <= 1'b0;
                    out1  <= 1'b0;
                end
                CTC: begin
                    if (match0) begin
                        count <= '0;
                        out0  <= ~out0;        // Toggle per compare period
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                PWM: begin
                    count <= count + 1'b1;     // Wraps after 255
                    if (count == COUNT_TOP) begin
                        out0 <= 1'b1;          // Period restarts at 0
                        out1 <= 1'b1;
                    end else begin
                        if (match0) out0 <= 1'b0;
                        if (match1) out1 <= 1'b0;
                    end
                end
                default: ;                     // HOLD
            endcase
        end
    end

    assign tcfg.count = count;
    assign tcfg.out0  = out0;
    assign tcfg.out1  = out1;

    // ******************************
    // Tracks a completed CTC match with cmpr0 unchanged since
    always_ff @(posedge clk) begin
        if (reset) begin
            ctc_synced <= 1'b0;
            cmpr0_seen <= '0;
        end else begin
            cmpr0_seen <= tcfg.cmpr0;
            if (tcfg.mode != CTC || tcfg.cmpr0 != cmpr0_seen) begin
                ctc_synced <= 1'b0;
            end else if (tick && match0) begin
                ctc_synced <= 1'b1;
            end
        end
    end

    a_tick_single: assert property (
        @(posedge clk) disable iff (reset)
        (tick && tcfg.scale_factor != '0) |=> !tick
    ) else $error("prescaler tick held for two cycles");

    a_ctc_bound: assert property (
        @(posedge clk) disable iff (reset)
        (ctc_synced && tcfg.mode == CTC && tcfg.cmpr0 == cmpr0_seen) |-> count <= tcfg.cmpr0
    ) else $error("CTC count above compare 0");

endmodule

`default_nettype wire

/* hdl/io_periph.sv */
`default_nettype none

`include "io_settings.svh"

module io_periph (
    input  logic                  clk,
    input  logic                  reset,
    // Processor bus
    input  logic [`IO_ADDR_W-1:0] address,
    input  logic [`IO_DATA_W-1:0] din,
    input  logic                  w_en,
    input  logic                  r_en,
    output logic [`IO_DATA_W-1:0] dout,
    // Pad, tri-state buffer sits outside
    input  logic [`IO_DATA_W-1:0] pin_in,
    output logic [`IO_DATA_W-1:0] pin_out,
    output logic [`IO_DATA_W-1:0] pin_oe
);

    timer_cfg_if u_tcfg ();

    io_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .address (address),
        .din     (din),
        .w_en    (w_en),
        .r_en    (r_en),
        .dout    (dout),
        .pin_in  (pin_in),
        .pin_out (pin_out),
        .pin_oe  (pin_oe),
        .tcfg    (u_tcfg.cfg)
    );

    counter_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .tcfg  (u_tcfg.tmr)
    );

endmodule

`default_nettype wire

/* dv/io_periph_tb.sv */
`default_nettype none

`include "io_settings.svh"

module io_periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import io_pkg::*;

    localparam int WAIT_LIMIT = 300000;  // Covers a full 16-bit prescaler wrap

    logic                  clk;
    logic                  reset;
    logic [`IO_ADDR_W-1:0] address;
    logic [`IO_DATA_W-1:0] din;
    logic                  w_en;
    logic                  r_en;
    logic [`IO_DATA_W-1:0] dout;
    logic [`IO_DATA_W-1:0] pin_in;
    logic [`IO_DATA_W-1:0] pin_out;
    logic [`IO_DATA_W-1:0] pin_oe;
    logic [31:0]           rng;

    io_periph u_dut (
        .clk     (clk),
        .reset   (reset),
        .address (address),
        .din     (din),
        .w_en    (w_en),
        .r_en    (r_en),
        .dout    (dout),
        .pin_in  (pin_in),
        .pin_out (pin_out),
        .pin_oe  (pin_oe)
    );

    always #50 clk = ~clk;

    // ******************************
    // Helpers
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAIL %s expected %0d actual %0d", test, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        rng = xorshift(rng);
        b   = rng[7:0];
    endtask

    task automatic bus_write(input logic [`IO_ADDR_W-1:0] a, input logic [`IO_DATA_W-1:0] d);
        @(posedge clk);
        address <= a;
        din     <= d;
        w_en    <= 1'b1;
        @(posedge clk);
        w_en    <= 1'b0;
    endtask

    task automatic bus_read(input logic [`IO_ADDR_W-1:0] a, output logic [`IO_DATA_W-1:0] d);
        @(posedge clk);
        address <= a;
        r_en    <= 1'b1;
        @(posedge clk);
        r_en    <= 1'b0;
        @(negedge clk);   // dout settled one cycle after the strobe
        d = dout;
    endtask

    // Counts clocks until the pin reaches the level
    task automatic wait_pin_level(input int idx, input logic level, output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_run($sformatf("Timeout waiting for pin %0d to reach %0b", idx, level));
            end
        end while (pin_out[idx] !== level);
        cycles = n;
    endtask

    // ******************************
    // Directed tests
    task automatic test_reset_values();
        logic [7:0] value;
        for (int a = 0; a <= 8; a++) begin
            bus_read(8'(a), value);
            check($sformatf("reset_addr_%0d", a), 0, value);
        end
        check("reset_oe", 0, pin_oe);
    endtask

    task automatic test_readback();
        logic [7:0] wdata [9];
        logic [7:0] value;
        for (int a = 0; a <= 7; a++) begin
            next_byte(value);
            if (a == CTRL) begin
                value = {value[7:4], 2'b00, value[0], value[0]};  // Idle or hold, no routing
            end
            wdata[a] = value;
            if (a != PINS) bus_write(8'(a), value);
        end
        for (int a = 0; a <= 7; a++) begin
            if (a != PINS) begin
                bus_read(8'(a), value);
                check($sformatf("readback_addr_%0d", a), wdata[a], value);
            end
        end
        @(negedge clk);
        check("readback_oe", wdata[DIR], pin_oe);
        check("readback_out", wdata[PORT], pin_out);
        next_byte(value);
        @(posedge clk);
        pin_in <= value;
        wdata[PINS] = value;
        bus_write(PINS, ~value);       // Read only
        bus_write(COUNT, 8'hA5);       // Read only
        bus_write(CTRL, 8'h00);
        bus_read(PINS, value);
        check("readback_pins", wdata[PINS], value);
        bus_read(COUNT, value);
        check("readback_count", 0, value);
    endtask

    task automatic test_ctc(input logic [15:0] s, input logic [7:0] n);
        int   cycles;
        int   expected;
        logic lvl;
        bus_write(SCALE_LO, s[7:0]);
        bus_write(SCALE_HI, s[15:8]);
        bus_write(CMPR0, n);
        bus_write(CTRL, 8'h05);        // CTC, out0 onto pin 6
        @(negedge clk);
        lvl = pin_out[6];
        wait_pin_level(6, ~lvl, cycles);  // First toggle only syncs
        wait_pin_level(6, lvl, cycles);
        expected = (int'(n) + 1) * (int'(s) + 1);
        check($sformatf("ctc_period_s%0d_n%0d", s, n), expected, cycles);
    endtask

    task automatic test_pwm();
        logic [7:0] c0;
        logic [7:0] c1;
        int         cycles;
        int         high0;
        int         high1;
        next_byte(c0);
        next_byte(c1);
        c0 = c0 % 200 + 8'd10;         // Keeps a low phase on pin 6
        bus_write(SCALE_LO, 8'h00);
        bus_write(SCALE_HI, 8'h00);
        bus_write(CMPR0, c0);
        bus_write(CMPR1, c1);
        bus_write(CTRL, 8'h0E);        // PWM, both outputs routed
        wait_pin_level(6, 1'b0, cycles);
        wait_pin_level(6, 1'b1, cycles);  // Period start
        high0 = 0;
        high1 = 0;
        for (int i = 0; i < 256; i++) begin
            if (pin_out[6]) high0++;
            if (pin_out[7]) high1++;
            @(negedge clk);
        end
        check("pwm_duty0", c0 + 1, high0);
        check("pwm_duty1", c1 + 1, high1);
    endtask

    task automatic test_idle();
        int         cycles;
        logic [7:0] value;
        bus_write(SCALE_LO, 8'd3);
        bus_write(SCALE_HI, 8'd0);
        bus_write(CMPR0, 8'd20);
        bus_write(CTRL, 8'h05);
        wait_pin_level(6, 1'b1, cycles);
        bus_write(CTRL, 8'h04);        // Idle, routing kept
        wait_pin_level(6, 1'b0, cycles);
        bus_read(COUNT, value);
        check("idle_count", 0, value);
        bus_write(PORT, 8'h40);
        bus_write(CTRL, 8'h00);
        @(negedge clk);
        check("idle_pin6_port_high", 1, pin_out[6]);
        bus_write(PORT, 8'h00);
        @(negedge clk);
        check("idle_pin6_port_low", 0, pin_out[6]);
    endtask

    // ******************************
    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        address = '0;
        din     = '0;
        w_en    = 1'b0;
        r_en    = 1'b0;
        pin_in  = '0;
        rng     = 32'd90241;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_readback();
        test_ctc(16'd2, 8'd4);
        test_ctc(16'd5, 8'd9);
        test_pwm();
        test_idle();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/io_pkg.sv
hdl/timer_cfg_if.sv
hdl/io_regs.sv
hdl/counter_timer.sv
hdl/io_periph.sv
dv/io_periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the io_periph testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f verilog.f --top-module io_periph_tb

output=$(./obj_dir/Vio_periph_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "No errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
